//--- common/lpif_pkg.sv
`default_nettype none

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // link geometry, fixed 256b word over four 64b beats
  ////////////////////////////////////////////////////////////
  localparam int LP_DATA_W  = 256;
  localparam int BEAT_W     = 64;
  localparam int NUM_BEATS  = LP_DATA_W / BEAT_W;
  localparam int BEAT_IDX_W = $clog2(NUM_BEATS);
  localparam int AIB_LANES  = 4;
  localparam int STREAM_W   = 8;
  localparam int PROTID_W   = 2;

  localparam logic [BEAT_IDX_W-1:0] LAST_BEAT = BEAT_IDX_W'(NUM_BEATS - 1);

  // lpif stream ids
  localparam logic [STREAM_W-1:0] MEM_CACHE_STREAM_ID = 8'h01;
  localparam logic [STREAM_W-1:0] IO_STREAM_ID        = 8'h02;
  localparam logic [STREAM_W-1:0] ARB_MUX_STREAM_ID   = 8'h03;

  // protocol ids on the beat streams
  localparam logic [PROTID_W-1:0] PROTID_CACHE   = 2'd0;
  localparam logic [PROTID_W-1:0] PROTID_IO      = 2'd1;
  localparam logic [PROTID_W-1:0] PROTID_ARB_MUX = 2'd2;

  typedef logic [LP_DATA_W-1:0] lp_word_t;
  typedef logic [BEAT_W-1:0]    beat_t;

  typedef enum logic [2:0]
  {
    CTL_IDLE       = 3'd0,
    CTL_PHY_INIT   = 3'd1,
    CTL_CFG        = 3'd2,
    CTL_CALIB      = 3'd3,
    CTL_WAIT_ALIGN = 3'd4,
    CTL_LINK_UP    = 3'd5,
    CTL_PHY_ERR    = 3'd6
  } ctl_state_t;

  // downstream direction, unknown streams fall back to cache
  function automatic logic [PROTID_W-1:0] stream_to_protid(input logic [STREAM_W-1:0] stream);
    logic [PROTID_W-1:0] protid;
    case (stream)
      IO_STREAM_ID:      protid = PROTID_IO;
      ARB_MUX_STREAM_ID: protid = PROTID_ARB_MUX;
      default:           protid = PROTID_CACHE;
    endcase
    return protid;
  endfunction

  // upstream direction, protid 3 is unused and lands on cache
  function automatic logic [STREAM_W-1:0] protid_to_stream(input logic [PROTID_W-1:0] protid);
    logic [STREAM_W-1:0] stream;
    case (protid)
      PROTID_IO:      stream = IO_STREAM_ID;
      PROTID_ARB_MUX: stream = ARB_MUX_STREAM_ID;
      default:        stream = MEM_CACHE_STREAM_ID;
    endcase
    return stream;
  endfunction

endpackage

`default_nettype wire

//--- dstrm/dstrm_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module dstrm_splitter
(
  input  wire logic                          lclk,
  input  wire logic                          rst_n,

  input  wire logic                          ctl_link_up,

  input  wire logic                          lp_irdy,
  input  wire lpif_pkg::lp_word_t            lp_data,
  input  wire logic [lpif_pkg::STREAM_W-1:0] lp_stream,
  output logic                               pl_trdy,

  output logic                               dstrm_valid,
  output lpif_pkg::beat_t                    dstrm_data,
  output logic [lpif_pkg::PROTID_W-1:0]      dstrm_protid
);

  lpif_pkg::lp_word_t                hold_data;  // word being sent
  logic [lpif_pkg::BEAT_IDX_W-1:0]   beat_cnt;
  logic                              last_beat;
  logic                              accept;

  assign last_beat = (beat_cnt == lpif_pkg::LAST_BEAT);

  // idle or on the final beat, so the next word overlaps
  assign pl_trdy = ctl_link_up & (~dstrm_valid | last_beat);
  assign accept  = lp_irdy & pl_trdy;

  ////////////////////////////////////////////////////////////
  // beat sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dstrm_valid <= 1'b0;
      beat_cnt    <= '0;
    end
    else if (accept)
    begin
      dstrm_valid <= 1'b1;
      beat_cnt    <= '0;  // low beat goes out first
    end
    else if (dstrm_valid)
    begin
      if (last_beat)
        dstrm_valid <= 1'b0;
      beat_cnt <= beat_cnt + 1'b1;  // wraps back to zero
    end
  end

  // capture word and translated id on acceptance
  always_ff @(posedge lclk)
  begin
    if (accept)
    begin
      hold_data    <= lp_data;
      dstrm_protid <= lpif_pkg::stream_to_protid(lp_stream);
    end
  end

  // current 64b slice of the held word
  assign dstrm_data = hold_data[beat_cnt * lpif_pkg::BEAT_W +: lpif_pkg::BEAT_W];

endmodule

`default_nettype wire

//--- link_ctl/link_ctl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module link_ctl_fsm
(
  input  wire logic                           lclk,
  input  wire logic                           rst_n,

  input  wire logic                           i_conf_done,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] ms_tx_transfer_en,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] sl_tx_transfer_en,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] wa_error,
  input  wire logic                           align_done,
  input  wire logic                           align_err,
  input  wire logic                           lp_linkerror,

  output logic                                ns_mac_rdy,
  output logic [lpif_pkg::AIB_LANES-1:0]      ns_adapter_rstn,
  output logic                                tx_online,
  output logic                                rx_online,
  output logic                                ctl_link_up,
  output logic                                ctl_phy_err
);

  lpif_pkg::ctl_state_t state;
  lpif_pkg::ctl_state_t state_nxt;

  logic all_xfer_en;
  logic phy_err;

  // every lane of both directions enabled
  assign all_xfer_en = (&ms_tx_transfer_en) & (&sl_tx_transfer_en);

  // lane status problems, only acted on while link is up
  assign phy_err = ~all_xfer_en | (|wa_error) | align_err | lp_linkerror;

  assign ctl_link_up = (state == lpif_pkg::CTL_LINK_UP);
  assign ctl_phy_err = (state == lpif_pkg::CTL_PHY_ERR);

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_nxt = state;
    case (state)
      lpif_pkg::CTL_IDLE:       state_nxt = lpif_pkg::CTL_PHY_INIT;
      lpif_pkg::CTL_PHY_INIT:
        if (i_conf_done)
          state_nxt = lpif_pkg::CTL_CFG;
      lpif_pkg::CTL_CFG:        state_nxt = lpif_pkg::CTL_CALIB;  // single cycle
      lpif_pkg::CTL_CALIB:
        if (all_xfer_en)
          state_nxt = lpif_pkg::CTL_WAIT_ALIGN;
      lpif_pkg::CTL_WAIT_ALIGN:
        if (align_done)
          state_nxt = lpif_pkg::CTL_LINK_UP;
      lpif_pkg::CTL_LINK_UP:
        if (phy_err)
          state_nxt = lpif_pkg::CTL_PHY_ERR;
      lpif_pkg::CTL_PHY_ERR:    state_nxt = lpif_pkg::CTL_PHY_ERR;  // sticky until reset
      default:                  state_nxt = lpif_pkg::CTL_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and sticky aib controls
  ////////////////////////////////////////////////////////////
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state           <= lpif_pkg::CTL_IDLE;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == lpif_pkg::CTL_PHY_INIT && i_conf_done)
        ns_mac_rdy <= 1'b1;
      if (state == lpif_pkg::CTL_CFG)
        ns_adapter_rstn <= '1;  // release adapter reset on all lanes
      if (state == lpif_pkg::CTL_CALIB && all_xfer_en)
      begin
        tx_online <= 1'b1;
        rx_online <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run with Verilator; exit status is nonzero on any failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_lpif_ctl -f sim.f \
  && ./obj_dir/Vtb_lpif_ctl \
  || exit 1

//--- sim.f
common/lpif_pkg.sv
link_ctl/link_ctl_fsm.sv
dstrm/dstrm_splitter.sv
ustrm/ustrm_gatherer.sv
source/lpif_ctl_top.sv
testbench/lpif_ctl_sva.sv
testbench/tb_clkgen.sv
testbench/tb_lpif_ctl.sv

//--- source/lpif_ctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_ctl_top
(
  input  wire logic                           lclk,
  input  wire logic                           rst_n,

  // lpif downstream
  input  wire logic                           lp_irdy,
  input  wire lpif_pkg::lp_word_t             lp_data,
  input  wire logic [lpif_pkg::STREAM_W-1:0]  lp_stream,
  output logic                                pl_trdy,

  // downstream beats toward aib
  output logic                                dstrm_valid,
  output lpif_pkg::beat_t                     dstrm_data,
  output logic [lpif_pkg::PROTID_W-1:0]       dstrm_protid,

  // upstream beats from aib
  input  wire logic                           ustrm_valid,
  input  wire lpif_pkg::beat_t                ustrm_data,
  input  wire logic [lpif_pkg::PROTID_W-1:0]  ustrm_protid,

  // lpif upstream
  output logic                                pl_valid,
  output lpif_pkg::lp_word_t                  pl_data,
  output logic [lpif_pkg::STREAM_W-1:0]       pl_stream,

  // aib control and status
  input  wire logic                           i_conf_done,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] ms_tx_transfer_en,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] sl_tx_transfer_en,
  input  wire logic [lpif_pkg::AIB_LANES-1:0] wa_error,
  input  wire logic                           align_done,
  input  wire logic                           align_err,
  input  wire logic                           lp_linkerror,
  output logic                                ns_mac_rdy,
  output logic [lpif_pkg::AIB_LANES-1:0]      ns_adapter_rstn,
  output logic                                tx_online,
  output logic                                rx_online,
  output logic                                ctl_link_up,
  output logic                                ctl_phy_err
);

  link_ctl_fsm link_ctl_fsm_i
  (
    .lclk              (lclk),
    .rst_n             (rst_n),
    .i_conf_done       (i_conf_done),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .sl_tx_transfer_en (sl_tx_transfer_en),
    .wa_error          (wa_error),
    .align_done        (align_done),
    .align_err         (align_err),
    .lp_linkerror      (lp_linkerror),
    .ns_mac_rdy        (ns_mac_rdy),
    .ns_adapter_rstn   (ns_adapter_rstn),
    .tx_online         (tx_online),
    .rx_online         (rx_online),
    .ctl_link_up       (ctl_link_up),
    .ctl_phy_err       (ctl_phy_err)
  );

  // gated by link state from the fsm
  dstrm_splitter dstrm_splitter_i
  (
    .lclk         (lclk),
    .rst_n        (rst_n),
    .ctl_link_up  (ctl_link_up),
    .lp_irdy      (lp_irdy),
    .lp_data      (lp_data),
    .lp_stream    (lp_stream),
    .pl_trdy      (pl_trdy),
    .dstrm_valid  (dstrm_valid),
    .dstrm_data   (dstrm_data),
    .dstrm_protid (dstrm_protid)
  );

  ustrm_gatherer ustrm_gatherer_i
  (
    .lclk         (lclk),
    .rst_n        (rst_n),
    .ustrm_valid  (ustrm_valid),
    .ustrm_data   (ustrm_data),
    .ustrm_protid (ustrm_protid),
    .pl_valid     (pl_valid),
    .pl_data      (pl_data),
    .pl_stream    (pl_stream)
  );

endmodule

`default_nettype wire

//--- testbench/lpif_ctl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_ctl_sva
(
  input wire logic                           lclk,
  input wire logic                           rst_n,
  input wire logic                           lp_irdy,
  input wire logic                           pl_trdy,
  input wire logic                           dstrm_valid,
  input wire logic                           ctl_link_up,
  input wire logic                           ctl_phy_err,
  input wire logic [lpif_pkg::AIB_LANES-1:0] ms_tx_transfer_en,
  input wire logic [lpif_pkg::AIB_LANES-1:0] sl_tx_transfer_en,
  input wire logic [lpif_pkg::AIB_LANES-1:0] wa_error,
  input wire logic                           align_err,
  input wire logic                           lp_linkerror
);

  logic accept;
  logic lane_err;

  assign accept   = lp_irdy & pl_trdy;
  assign lane_err = ~(&ms_tx_transfer_en) | ~(&sl_tx_transfer_en) | (|wa_error)
                  | align_err | lp_linkerror;

  ////////////////////////////////////////////////////////////
  // downstream handshake
  ////////////////////////////////////////////////////////////
  no_accept_link_down: assert property (@(posedge lclk) disable iff (!rst_n)
    accept |-> ctl_link_up)
    else $error("downstream word accepted while the link is down");

  // four beats, then idle unless the next word was taken on the last beat
  four_beats_per_word: assert property (@(posedge lclk) disable iff (!rst_n)
    accept |=> dstrm_valid ##1 dstrm_valid ##1 dstrm_valid ##1 dstrm_valid
      ##1 (dstrm_valid == $past(accept)))
    else $error("accepted word did not give exactly four downstream beats");

  ////////////////////////////////////////////////////////////
  // phy error
  ////////////////////////////////////////////////////////////
  phy_err_follows: assert property (@(posedge lclk) disable iff (!rst_n)
    (ctl_link_up && lane_err) |=> ctl_phy_err)
    else $error("phy error during link up did not raise ctl_phy_err");

  phy_err_sticky: assert property (@(posedge lclk) disable iff (!rst_n)
    ctl_phy_err |=> (ctl_phy_err && !ctl_link_up))
    else $error("ctl_phy_err dropped or link came back before reset");

endmodule

bind lpif_ctl_top lpif_ctl_sva lpif_ctl_sva_i
(
  .lclk              (lclk),
  .rst_n             (rst_n),
  .lp_irdy           (lp_irdy),
  .pl_trdy           (pl_trdy),
  .dstrm_valid       (dstrm_valid),
  .ctl_link_up       (ctl_link_up),
  .ctl_phy_err       (ctl_phy_err),
  .ms_tx_transfer_en (ms_tx_transfer_en),
  .sl_tx_transfer_en (sl_tx_transfer_en),
  .wa_error          (wa_error),
  .align_err         (align_err),
  .lp_linkerror      (lp_linkerror)
);

`default_nettype wire

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
  output logic lclk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 4;  // 8 ns clock
  localparam int RESET_CYCLES   = 5;

  initial
  begin
    lclk = 1'b0;
    forever #(HALF_PERIOD_NS) lclk = ~lclk;
  end

  // release on a rising edge, like the rest of the stimulus
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge lclk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_lpif_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_ctl;

  localparam int NUM_WORDS      = 8;
  localparam int TIMEOUT_CYCLES = 40 + NUM_WORDS * lpif_pkg::NUM_BEATS * 2 * 4 + 50;

  logic lclk;
  logic rst_n;
  logic lp_irdy;
  lpif_pkg::lp_word_t lp_data;
  logic [7:0] lp_stream;
  logic pl_trdy;
  logic dstrm_valid;
  lpif_pkg::beat_t dstrm_data;
  logic [1:0] dstrm_protid;
  logic ustrm_valid;
  lpif_pkg::beat_t ustrm_data;
  logic [1:0] ustrm_protid;
  logic pl_valid;
  lpif_pkg::lp_word_t pl_data;
  logic [7:0] pl_stream;
  logic i_conf_done;
  logic [3:0] ms_tx_transfer_en;
  logic [3:0] sl_tx_transfer_en;
  logic [3:0] wa_error;
  logic align_done;
  logic align_err;
  logic lp_linkerror;
  logic ns_mac_rdy;
  logic [3:0] ns_adapter_rstn;
  logic tx_online;
  logic rx_online;
  logic ctl_link_up;
  logic ctl_phy_err;

  // expected words in acceptance order
  lpif_pkg::lp_word_t dn_words[$];
  logic [1:0]         dn_protid[$];
  lpif_pkg::lp_word_t up_words[$];
  logic [7:0]         up_stream[$];
  int dn_beat = 0;

  tb_clkgen clkgen_i (.lclk(lclk), .rst_n(rst_n));

  lpif_ctl_top lpif_ctl_top_i
  (
    .lclk(lclk), .rst_n(rst_n),
    .lp_irdy(lp_irdy), .lp_data(lp_data), .lp_stream(lp_stream), .pl_trdy(pl_trdy),
    .dstrm_valid(dstrm_valid), .dstrm_data(dstrm_data), .dstrm_protid(dstrm_protid),
    .ustrm_valid(ustrm_valid), .ustrm_data(ustrm_data), .ustrm_protid(ustrm_protid),
    .pl_valid(pl_valid), .pl_data(pl_data), .pl_stream(pl_stream),
    .i_conf_done(i_conf_done), .ms_tx_transfer_en(ms_tx_transfer_en),
    .sl_tx_transfer_en(sl_tx_transfer_en), .wa_error(wa_error),
    .align_done(align_done), .align_err(align_err), .lp_linkerror(lp_linkerror),
    .ns_mac_rdy(ns_mac_rdy), .ns_adapter_rstn(ns_adapter_rstn),
    .tx_online(tx_online), .rx_online(rx_online),
    .ctl_link_up(ctl_link_up), .ctl_phy_err(ctl_phy_err)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input string expected, input string actual);
    stop_run($sformatf("Mismatch at %0t ns: %s expected %s actual %s",
                       $time, name, expected, actual));
  endtask

  // unknown stream ids go to cache
  function automatic logic [1:0] expect_protid(input logic [7:0] stream);
    if (stream == lpif_pkg::IO_STREAM_ID)
      return lpif_pkg::PROTID_IO;
    else if (stream == lpif_pkg::ARB_MUX_STREAM_ID)
      return lpif_pkg::PROTID_ARB_MUX;
    return lpif_pkg::PROTID_CACHE;
  endfunction

  function automatic logic [7:0] expect_stream(input logic [1:0] protid);
    if (protid == lpif_pkg::PROTID_IO)
      return lpif_pkg::IO_STREAM_ID;
    else if (protid == lpif_pkg::PROTID_ARB_MUX)
      return lpif_pkg::ARB_MUX_STREAM_ID;
    return lpif_pkg::MEM_CACHE_STREAM_ID;  // cache and the spare id 3
  endfunction

  function automatic lpif_pkg::lp_word_t random_word();
    lpif_pkg::lp_word_t w;
    for (int i = 0; i < lpif_pkg::LP_DATA_W / 32; i++)
      w[i*32 +: 32] = $urandom;
    return w;
  endfunction

  // offer one word and hold it until taken
  task automatic send_word(input lpif_pkg::lp_word_t word, input logic [7:0] stream);
    logic taken;
    lp_irdy   <= 1'b1;
    lp_data   <= word;
    lp_stream <= stream;
    do
    begin
      @(negedge lclk);
      taken = pl_trdy;
      @(posedge lclk);
    end while (!taken);
    dn_words.push_back(word);
    dn_protid.push_back(expect_protid(stream));
  endtask

  task automatic send_group(input bit with_gaps, input logic [1:0] last_pid);
    lpif_pkg::lp_word_t word;
    logic [1:0] pid;
    word = random_word();
    pid  = '0;
    for (int b = 0; b < lpif_pkg::NUM_BEATS; b++)
    begin
      if (with_gaps)
      begin
        ustrm_valid <= 1'b0;
        repeat ($urandom % 3) @(posedge lclk);
      end
      if (b == lpif_pkg::NUM_BEATS - 1)
        pid = last_pid;
      else
        pid = 2'($urandom);
      ustrm_valid  <= 1'b1;
      ustrm_data   <= word[b*lpif_pkg::BEAT_W +: lpif_pkg::BEAT_W];
      ustrm_protid <= pid;
      @(posedge lclk);
    end
    up_words.push_back(word);
    up_stream.push_back(expect_stream(pid));  // id of the fourth beat
  endtask

  ////////////////////////////////////////////////////////////
  // output checks at the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge lclk)
  begin : check_outputs
    lpif_pkg::beat_t exp_beat;
    logic exp_trdy;
    if (rst_n)
    begin
      if (!ctl_link_up)
        assert (!pl_trdy) else stop_run("pl_trdy is high while the link is not up");
      if (ns_mac_rdy)
        assert (i_conf_done) else stop_run("ns_mac_rdy rose before i_conf_done");
      if (ns_adapter_rstn != '0)
        assert ((&ns_adapter_rstn) && ns_mac_rdy)
          else stop_run("ns_adapter_rstn released on part of the lanes or before ns_mac_rdy");
      if (tx_online || rx_online)
        assert ((&ms_tx_transfer_en) && (&sl_tx_transfer_en))
          else stop_run("tx/rx online rose before all transfer enables were high");
      if (ctl_link_up)
        assert (align_done) else stop_run("ctl_link_up rose before align_done");
      if (ctl_link_up)
        assert (ns_mac_rdy && tx_online && rx_online && (&ns_adapter_rstn))
          else stop_run("link up before mac ready, adapter reset release and tx/rx online");

      assert (dstrm_valid == (dn_words.size() != 0))
        else stop_run("dstrm_valid does not follow the accepted words");
      if (ctl_link_up)
      begin
        // ready when idle or on the last beat
        exp_trdy = (dn_words.size() == 0) || (dn_beat == lpif_pkg::NUM_BEATS - 1);
        assert (pl_trdy == exp_trdy)
          else report_mismatch("pl_trdy", $sformatf("%b", exp_trdy),
                               $sformatf("%b", pl_trdy));
      end
      if (dstrm_valid && dn_words.size() != 0)
      begin
        exp_beat = dn_words[0][dn_beat*lpif_pkg::BEAT_W +: lpif_pkg::BEAT_W];
        assert (dstrm_data == exp_beat)
          else report_mismatch("dstrm_data", $sformatf("%h", exp_beat),
                               $sformatf("%h", dstrm_data));
        assert (dstrm_protid == dn_protid[0])
          else report_mismatch("dstrm_protid", $sformatf("%h", dn_protid[0]),
                               $sformatf("%h", dstrm_protid));
        dn_beat = dn_beat + 1;
        if (dn_beat == lpif_pkg::NUM_BEATS)
        begin
          dn_beat = 0;
          void'(dn_words.pop_front());
          void'(dn_protid.pop_front());
        end
      end

      assert (pl_valid == (up_words.size() != 0))
        else stop_run("pl_valid does not follow the completed beat groups");
      if (pl_valid && up_words.size() != 0)
      begin
        assert (pl_data == up_words[0])
          else report_mismatch("pl_data", $sformatf("%h", up_words[0]),
                               $sformatf("%h", pl_data));
        assert (pl_stream == up_stream[0])
          else report_mismatch("pl_stream", $sformatf("%h", up_stream[0]),
                               $sformatf("%h", pl_stream));
        void'(up_words.pop_front());
        void'(up_stream.pop_front());
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge lclk);
    stop_run("watchdog expired before the test sequence finished");
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin : sequence_main
    logic [3:0] err_mask;
    void'($urandom(24));
    lp_irdy = 1'b0;
    lp_data = '0;
    lp_stream = '0;
    ustrm_valid = 1'b0;
    ustrm_data = '0;
    ustrm_protid = '0;
    i_conf_done = 1'b0;
    ms_tx_transfer_en = '0;
    sl_tx_transfer_en = '0;
    wa_error = '0;
    align_done = 1'b0;
    align_err = 1'b0;
    lp_linkerror = 1'b0;
    err_mask = '0;

    wait (rst_n === 1'b1);
    repeat (3) @(posedge lclk);
    i_conf_done <= 1'b1;
    repeat (3) @(posedge lclk);
    ms_tx_transfer_en <= '1;  // one side only so calib keeps waiting
    repeat (3) @(posedge lclk);
    sl_tx_transfer_en <= '1;
    repeat (3) @(posedge lclk);
    align_done <= 1'b1;
    while (!ctl_link_up) @(posedge lclk);

    for (int i = 0; i < NUM_WORDS; i++)
      send_word(random_word(), 8'(i % 5));  // 0 and 4 are unknown ids
    lp_irdy <= 1'b0;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      lp_irdy <= 1'b0;
      repeat ($urandom % 4) @(posedge lclk);
      send_word(random_word(), 8'($urandom % 5));
    end
    lp_irdy <= 1'b0;

    for (int i = 0; i < NUM_WORDS; i++)
      send_group(1'b0, 2'(i));
    for (int i = 0; i < NUM_WORDS; i++)
      send_group(1'b1, 2'(i));
    ustrm_valid <= 1'b0;
    repeat (8) @(posedge lclk);

    // single lane error during link up
    err_mask[$urandom % 4] = 1'b1;
    wa_error <= err_mask;
    @(posedge lclk);
    wa_error <= '0;
    lp_irdy  <= 1'b1;  // offered word must never be taken
    repeat (4)
    begin
      @(negedge lclk);
      assert (ctl_phy_err && !ctl_link_up && !pl_trdy)
        else stop_run("link did not stay in phy error after a wa_error bit");
    end

    if (dn_words.size() != 0 || up_words.size() != 0)
      stop_run("words still expected at the end of the run");
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- ustrm/ustrm_gatherer.sv
`timescale 1ns/1ps
`default_nettype none

module ustrm_gatherer
(
  input  wire logic                          lclk,
  input  wire logic                          rst_n,

  input  wire logic                          ustrm_valid,
  input  wire lpif_pkg::beat_t               ustrm_data,
  input  wire logic [lpif_pkg::PROTID_W-1:0] ustrm_protid,

  output logic                               pl_valid,
  output lpif_pkg::lp_word_t                 pl_data,
  output logic [lpif_pkg::STREAM_W-1:0]      pl_stream
);

  lpif_pkg::lp_word_t              asm_data;  // partial word
  logic [lpif_pkg::BEAT_IDX_W-1:0] beat_cnt;
  logic                            group_done;

  // fourth beat of the group on the bus now
  assign group_done = ustrm_valid & (beat_cnt == lpif_pkg::LAST_BEAT);

  ////////////////////////////////////////////////////////////
  // beat count and valid pulse
  ////////////////////////////////////////////////////////////
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat_cnt <= '0;
      pl_valid <= 1'b0;
    end
    else
    begin
      if (ustrm_valid)
        beat_cnt <= beat_cnt + 1'b1;  // wraps, next group starts at once
      pl_valid <= group_done;  // one cycle only
    end
  end

  ////////////////////////////////////////////////////////////
  // assembly and output word
  ////////////////////////////////////////////////////////////
  always_ff @(posedge lclk)
  begin
    if (ustrm_valid)
      asm_data[beat_cnt * lpif_pkg::BEAT_W +: lpif_pkg::BEAT_W] <= ustrm_data;
  end

  always_ff @(posedge lclk)
  begin
    if (group_done)
    begin
      // last beat bypasses the assembly register
      pl_data   <= {ustrm_data, asm_data[lpif_pkg::LP_DATA_W-lpif_pkg::BEAT_W-1:0]};
      pl_stream <= lpif_pkg::protid_to_stream(ustrm_protid);
    end
  end

endmodule

`default_nettype wire
